//--- compile.f
+incdir+verilog
verilog/ig_pixel_pkg.sv
verilog/ig_ctrl_pkg.sv
verilog/ig_line_buffer.sv
verilog/ig_grad_calc.sv
verilog/ig_sequencer.sv
verilog/ig_top.sv
sim/ig_tb.sv

//--- Bender.yml
package:
  name: ig_gradient

export_include_dirs:
  - verilog

sources:
  - verilog/ig_pixel_pkg.sv
  - verilog/ig_ctrl_pkg.sv
  - verilog/ig_line_buffer.sv
  - verilog/ig_grad_calc.sv
  - verilog/ig_sequencer.sv
  - verilog/ig_top.sv
  - target: simulation
    files:
      - sim/ig_tb.sv

//--- sim/ig_tb.sv
`timescale 1ns/1ps
`include "ig_params.svh"

module ig_tb
    import ig_pixel_pkg::*;
    import ig_ctrl_pkg::*;
;

    localparam int W            = `IG_IMG_W;
    localparam int H            = `IG_IMG_H;
    localparam int NPIX         = W * H;
    localparam int NTESTS       = 5;
    localparam int TIMEOUT      = NPIX * 10;
    localparam int RANDOM_DELAY = -1;

    localparam int PAT_CONST  = 0;
    localparam int PAT_HRAMP  = 1;
    localparam int PAT_VRAMP  = 2;
    localparam int PAT_RANDOM = 3;

    // ------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------

    // level is the constant value or the ramp step
    // a negative delay means a random return delay of 0..7 cycles
    string test_name  [NTESTS] = '{"const_zero", "hramp", "vramp", "rand_slow", "rand_mixed"};
    int    test_pat   [NTESTS] = '{PAT_CONST, PAT_HRAMP, PAT_VRAMP, PAT_RANDOM, PAT_RANDOM};
    int    test_level [NTESTS] = '{8'h5a, 1, 1, 0, 0};
    int    test_delay [NTESTS] = '{0, 0, 3, 3, RANDOM_DELAY};
    int    test_wrs   [NTESTS] = '{NPIX, NPIX, NPIX, NPIX, NPIX};

    logic                           clk = 1'b0;
    logic                           reset;
    logic                           img_rd;
    logic [`IG_ADDR_W-1:0]          img_addr;
    pixel_t                         img_di;
    logic                           grad_wr;
    logic [`IG_ADDR_W-1:0]          grad_addr;
    logic [$bits(grad_word_u)-1:0]  grad_do;
    logic                           grad_credit;
    logic                           done;

    int         seed = 55886;
    int         test_idx;
    int         fail_count;
    int         write_count;
    int         edge_cnt;
    int         last_due;
    int         credit_due [$];
    credit_t    credit_mirror;
    logic       prev_done;
    logic       wr_last_edge;
    pixel_t     img_mem  [NPIX];
    grad_word_u grad_mem [NPIX];
    bit         written  [NPIX];

    ig_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .img_rd      (img_rd),
        .img_addr    (img_addr),
        .img_di      (img_di),
        .grad_wr     (grad_wr),
        .grad_addr   (grad_addr),
        .grad_do     (grad_do),
        .grad_credit (grad_credit),
        .done        (done)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_grad(input string name, input int addr,
                              input grad_word_u exp_w, input grad_word_u act_w);
        if ((act_w.parts.gx !== exp_w.parts.gx) || (act_w.parts.gy !== exp_w.parts.gy)) begin
            report_failure($sformatf(
                "Mismatch %s addr %0d: expected gx %0d gy %0d, actual gx %0d gy %0d",
                name, addr, $signed(exp_w.parts.gx), $signed(exp_w.parts.gy),
                $signed(act_w.parts.gx), $signed(act_w.parts.gy)));
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (exp_n !== act_n) begin
            report_failure($sformatf("Mismatch %s write count: expected %0d, actual %0d",
                name, exp_n, act_n));
        end
    endtask

    // forward differences with the right and bottom edges forced to zero
    function automatic grad_word_u expected_word(input int addr);
        grad_word_u w;
        int         r;
        int         c;
        r = addr / W;
        c = addr % W;
        if (c == W - 1) begin
            w.parts.gx = '0;
        end else begin
            w.parts.gx = grad_comp_t'(int'(img_mem[addr + 1]) - int'(img_mem[addr]));
        end
        if (r == H - 1) begin
            w.parts.gy = '0;
        end else begin
            w.parts.gy = grad_comp_t'(int'(img_mem[addr + W]) - int'(img_mem[addr]));
        end
        return w;
    endfunction

    function automatic int return_delay();
        if (test_delay[test_idx] < 0) begin
            return $random(seed) & 7;
        end
        return test_delay[test_idx];
    endfunction

    task automatic fill_image(input int t);
        for (int a = 0; a < NPIX; a++) begin
            case (test_pat[t])
                PAT_HRAMP:  img_mem[a] = pixel_t'((a % W) * test_level[t]);
                PAT_VRAMP:  img_mem[a] = pixel_t'((a / W) * test_level[t]);
                PAT_RANDOM: img_mem[a] = pixel_t'($random(seed));
                default:    img_mem[a] = pixel_t'(test_level[t]);
            endcase
            written[a] = 1'b0;
        end
    endtask

    // image memory with one cycle of read latency
    always @(posedge clk) begin
        if (img_rd) begin
            img_di <= img_mem[img_addr];
        end
    end

    // ------------------------------------------------------------------
    // gradient memory, credit return and done monitor
    // ------------------------------------------------------------------

    always @(posedge clk) begin
        int due;
        if (reset) begin
            grad_credit   <= 1'b0;
            credit_due.delete();
            last_due      = 0;
            credit_mirror = credit_t'(`IG_GRAD_CREDITS);
            write_count   = 0;
            prev_done     = 1'b0;
            wr_last_edge  = 1'b0;
        end else begin
            if (done && !prev_done && (!wr_last_edge || write_count != NPIX)) begin
                report_failure("done rose without the final write one cycle before");
            end
            if (prev_done && !done) begin
                report_failure("done dropped before the next reset");
            end
            if (done && grad_wr) begin
                report_failure("gradient write seen after done");
            end
            if (grad_wr) begin
                if (credit_mirror == '0) begin
                    report_failure("gradient write issued with no credit left");
                end
                if (grad_addr >= NPIX) begin
                    report_failure($sformatf("gradient write to address %0d out of range",
                        grad_addr));
                end
                if (written[grad_addr]) begin
                    report_failure($sformatf("address %0d written twice", grad_addr));
                end
                written[grad_addr]  = 1'b1;
                grad_mem[grad_addr] = grad_do;
                write_count++;
                due = edge_cnt + return_delay();
                // keep the return queue in order
                if (due < last_due) begin
                    due = last_due;
                end
                last_due = due;
                credit_due.push_back(due);
            end
            credit_mirror = credit_mirror - credit_t'(grad_wr) + credit_t'(grad_credit);
            if ((credit_due.size() > 0) && (credit_due[0] <= edge_cnt)) begin
                grad_credit <= 1'b1;
                void'(credit_due.pop_front());
            end else begin
                grad_credit <= 1'b0;
            end
            prev_done    = done;
            wr_last_edge = grad_wr;
        end
        edge_cnt++;
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------

    initial begin
        int cycles;
        reset       = 1'b1;
        img_di      = '0;
        grad_credit = 1'b0;
        fail_count  = 0;
        edge_cnt    = 0;
        test_idx    = 0;
        for (int t = 0; t < NTESTS; t++) begin
            @(posedge clk);
            reset <= 1'b1;
            test_idx = t;
            fill_image(t);
            repeat (8) @(posedge clk);
            reset <= 1'b0;
            @(posedge clk);
            if ((grad_wr !== 1'b0) || (done !== 1'b0) || (img_rd !== 1'b0)) begin
                report_failure($sformatf("test %s: outputs not idle right after reset",
                    test_name[t]));
            end
            cycles = 0;
            while (done !== 1'b1) begin
                if (cycles >= TIMEOUT) begin
                    report_failure("timeout waiting for done");
                end
                @(posedge clk);
                cycles++;
            end
            // done must hold with no further writes
            repeat (16) @(posedge clk);
            check_count(test_name[t], test_wrs[t], write_count);
            for (int a = 0; a < NPIX; a++) begin
                if (!written[a]) begin
                    report_failure($sformatf("test %s: address %0d never written",
                        test_name[t], a));
                end
                check_grad(test_name[t], a, expected_word(a), grad_mem[a]);
            end
            $display("test %s finished after %0d cycles", test_name[t], cycles);
        end
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/ig_top.sv
`timescale 1ns/1ps
`include "ig_params.svh"

module ig_top
    import ig_pixel_pkg::*;
    import ig_ctrl_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset,
    output logic                           img_rd,
    output logic [`IG_ADDR_W-1:0]          img_addr,
    input  pixel_t                         img_di,
    output logic                           grad_wr,
    output logic [`IG_ADDR_W-1:0]          grad_addr,
    output logic [$bits(grad_word_u)-1:0]  grad_do,
    input  logic                           grad_credit,
    output logic                           done
);

    logic                  pix_valid;
    logic                  pix_sel_zero;
    logic                  at_last_col;
    logic                  at_last_row;
    logic [`IG_ADDR_W-1:0] out_addr;
    pixel_t                pix_in;
    pixel_t                cur_pix;
    pixel_t                right_pix;
    pixel_t                down_pix;
    queue_cnt_t            queue_cnt;
    grad_word_u            grad_word;

    // flush steps push zeros below the last row
    assign pix_in  = pix_sel_zero ? pixel_t'(0) : img_di;
    assign grad_do = grad_word.raw;

    ig_sequencer seq0 (
        .clk          (clk),
        .reset        (reset),
        .grad_credit  (grad_credit),
        .queue_cnt    (queue_cnt),
        .img_rd       (img_rd),
        .img_addr     (img_addr),
        .pix_valid    (pix_valid),
        .pix_sel_zero (pix_sel_zero),
        .at_last_col  (at_last_col),
        .at_last_row  (at_last_row),
        .out_addr     (out_addr),
        .grad_wr      (grad_wr),
        .done         (done)
    );

    ig_line_buffer lbuf0 (
        .clk       (clk),
        .reset     (reset),
        .shift     (pix_valid),
        .pix_in    (pix_in),
        .cur_pix   (cur_pix),
        .right_pix (right_pix),
        .down_pix  (down_pix)
    );

    ig_grad_calc calc0 (
        .clk         (clk),
        .reset       (reset),
        .shift       (pix_valid),
        .cur_pix     (cur_pix),
        .right_pix   (right_pix),
        .down_pix    (down_pix),
        .at_last_col (at_last_col),
        .at_last_row (at_last_row),
        .out_addr    (out_addr),
        .pop         (grad_wr),
        .grad_word   (grad_word),
        .grad_addr   (grad_addr),
        .queue_cnt   (queue_cnt)
    );

endmodule

//--- verilog/ig_sequencer.sv
`timescale 1ns/1ps
`include "ig_params.svh"

module ig_sequencer
    import ig_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  grad_credit,
    input  queue_cnt_t            queue_cnt,
    output logic                  img_rd,
    output logic [`IG_ADDR_W-1:0] img_addr,
    output logic                  pix_valid,
    output logic                  pix_sel_zero,
    output logic                  at_last_col,
    output logic                  at_last_row,
    output logic [`IG_ADDR_W-1:0] out_addr,
    output logic                  grad_wr,
    output logic                  done
);

    localparam int W      = `IG_IMG_W;
    localparam int H      = `IG_IMG_H;
    localparam int NPIX   = W * H;
    localparam int NSTEP  = NPIX + W;
    localparam int CNT_W  = $clog2(NSTEP + 1);
    localparam int LEAD_W = $clog2(W + 1);
    localparam int COL_W  = $clog2(W);
    localparam int ROW_W  = $clog2(H);

    seq_state_t        state;
    credit_t           credits;
    logic [CNT_W-1:0]  step_cnt;
    logic [CNT_W-1:0]  wr_cnt;
    logic [LEAD_W-1:0] lead_cnt;
    logic [COL_W-1:0]  out_col;
    logic [ROW_W-1:0]  out_row;
    logic              flush_q;
    logic              formed;
    logic              issue;
    logic [2:0]        occupancy;

    // ------------------------------------------------------------------
    // issue control
    // ------------------------------------------------------------------

    // queued results plus the two pipeline stages ahead of the queue
    assign occupancy = 3'(queue_cnt) + 3'(img_rd) + 3'(flush_q) + 3'(pix_valid)
                     - 3'(grad_wr);
    assign issue = ((state == READ) || (state == FLUSH)) && (occupancy < 3'd2);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= READ;
            step_cnt     <= '0;
            img_rd       <= 1'b0;
            flush_q      <= 1'b0;
            pix_valid    <= 1'b0;
            pix_sel_zero <= 1'b0;
        end else begin
            img_rd       <= issue && (state == READ);
            flush_q      <= issue && (state == FLUSH);
            // read data or flush zero lands one cycle later
            pix_valid    <= img_rd || flush_q;
            pix_sel_zero <= flush_q;
            if (issue) begin
                step_cnt <= step_cnt + 1'b1;
            end
            case (state)
                READ: begin
                    if (issue && (step_cnt == CNT_W'(NPIX - 1))) begin
                        state <= FLUSH;
                    end
                end
                FLUSH: begin
                    if (issue && (step_cnt == CNT_W'(NSTEP - 1))) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (grad_wr && (wr_cnt == CNT_W'(NPIX - 1))) begin
                        state <= FINISH;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue && (state == READ)) begin
            img_addr <= `IG_ADDR_W'(step_cnt);
        end
    end

    // ------------------------------------------------------------------
    // output position trails the reads by W shifts
    // ------------------------------------------------------------------

    assign formed = (lead_cnt == LEAD_W'(W));

    always_ff @(posedge clk) begin
        if (reset) begin
            lead_cnt <= '0;
            out_addr <= '0;
            out_col  <= '0;
            out_row  <= '0;
        end else if (pix_valid) begin
            if (!formed) begin
                lead_cnt <= lead_cnt + 1'b1;
            end else begin
                out_addr <= out_addr + 1'b1;
                if (at_last_col) begin
                    out_col <= '0;
                    out_row <= out_row + 1'b1;
                end else begin
                    out_col <= out_col + 1'b1;
                end
            end
        end
    end

    assign at_last_col = (out_col == COL_W'(W - 1));
    assign at_last_row = (out_row == ROW_W'(H - 1));

    // ------------------------------------------------------------------
    // credits and write count
    // ------------------------------------------------------------------

    assign grad_wr = (queue_cnt != '0) && (credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= credit_t'(`IG_GRAD_CREDITS);
            wr_cnt  <= '0;
        end else begin
            credits <= credits + credit_t'(grad_credit) - credit_t'(grad_wr);
            if (grad_wr) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    assign done = (state == FINISH);

    // the memory returns no more credits than it was given
    assert property (@(posedge clk) disable iff (reset)
        credits <= credit_t'(`IG_GRAD_CREDITS))
        else $error("credit count above its maximum");

    // reads stop at the last pixel of the image
    assert property (@(posedge clk) disable iff (reset)
        (issue && (state == READ)) |-> (step_cnt < CNT_W'(NPIX)))
        else $error("image read beyond the last pixel");

endmodule

//--- verilog/ig_grad_calc.sv
`timescale 1ns/1ps
`include "ig_params.svh"

module ig_grad_calc
    import ig_pixel_pkg::*;
    import ig_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  shift,
    input  pixel_t                cur_pix,
    input  pixel_t                right_pix,
    input  pixel_t                down_pix,
    input  logic                  at_last_col,
    input  logic                  at_last_row,
    input  logic [`IG_ADDR_W-1:0] out_addr,
    input  logic                  pop,
    output grad_word_u            grad_word,
    output logic [`IG_ADDR_W-1:0] grad_addr,
    output queue_cnt_t            queue_cnt
);

    localparam int W      = `IG_IMG_W;
    localparam int FILL_W = $clog2(W + 1);

    logic [FILL_W-1:0]     fill_cnt;
    logic                  primed;
    logic                  push;
    grad_word_u            new_word;
    grad_word_u            q_word [2];
    logic [`IG_ADDR_W-1:0] q_addr [2];
    logic                  wr_ptr;
    logic                  rd_ptr;
    queue_cnt_t            count;

    function automatic grad_comp_t pix_diff(pixel_t a, pixel_t b);
        return grad_comp_t'({2'b00, a}) - grad_comp_t'({2'b00, b});
    endfunction

    // first row only fills the line buffer
    assign primed = (fill_cnt == FILL_W'(W));
    assign push   = shift && primed;

    always_ff @(posedge clk) begin
        if (reset) begin
            fill_cnt <= '0;
        end else if (shift && !primed) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // forward differences with zeros on the right and bottom edges
    always_comb begin
        new_word.parts.gx = at_last_col ? grad_comp_t'(0) : pix_diff(right_pix, cur_pix);
        new_word.parts.gy = at_last_row ? grad_comp_t'(0) : pix_diff(down_pix, cur_pix);
    end

    // ------------------------------------------------------------------
    // two-entry output queue
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (push) begin
            q_word[wr_ptr] <= new_word;
            q_addr[wr_ptr] <= out_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + queue_cnt_t'(push) - queue_cnt_t'(pop);
        end
    end

    assign grad_word = q_word[rd_ptr];
    assign grad_addr = q_addr[rd_ptr];
    assign queue_cnt = count;

    // the sequencer throttles issue so a result never meets a full queue
    assert property (@(posedge clk) disable iff (reset) push |-> (count < 2'd2))
        else $error("gradient pushed into a full queue");

endmodule

//--- verilog/ig_line_buffer.sv
`timescale 1ns/1ps
`include "ig_params.svh"

module ig_line_buffer
    import ig_pixel_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   shift,
    input  pixel_t pix_in,
    output pixel_t cur_pix,
    output pixel_t right_pix,
    output pixel_t down_pix
);

    localparam int W = `IG_IMG_W;

    // taps[0] is the newest sample, taps[W-1] the oldest
    // together with pix_in this covers one row plus one pixel
    pixel_t taps [W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < W; i++) begin
                taps[i] <= '0;
            end
        end else if (shift) begin
            taps[0] <= pix_in;
            for (int i = 1; i < W; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // ------------------------------------------------------------------
    // neighbor taps
    // ------------------------------------------------------------------

    // pixel i sits at the far end once pixel i+W is on pix_in
    assign cur_pix   = taps[W-1];

    // one step newer is the next pixel in raster order
    assign right_pix = taps[W-2];

    // the incoming sample is one full row below
    assign down_pix  = pix_in;

endmodule

//--- verilog/ig_ctrl_pkg.sv
`include "ig_params.svh"

package ig_ctrl_pkg;

    // sequencer phases
    typedef enum logic [1:0] {
        READ,
        FLUSH,
        DRAIN,
        FINISH
    } seq_state_t;

    // holds 0..IG_GRAD_CREDITS
    typedef logic [$clog2(`IG_GRAD_CREDITS + 1) - 1:0] credit_t;

    // entries in the two-deep output queue
    typedef logic [1:0] queue_cnt_t;

endpackage

//--- verilog/ig_pixel_pkg.sv
package ig_pixel_pkg;

    // grayscale sample as stored in the image memory
    typedef logic [7:0] pixel_t;

    // difference of two samples, range -255..255
    typedef logic signed [9:0] grad_comp_t;

    // one gradient memory word
    // raw is what the memory stores, parts splits it into gx (upper) and gy
    typedef union packed {
        logic [19:0] raw;
        struct packed {
            grad_comp_t gx;
            grad_comp_t gy;
        } parts;
    } grad_word_u;

endpackage

//--- verilog/ig_params.svh
`ifndef IG_PARAMS_SVH
`define IG_PARAMS_SVH

// ----------------------------------------------------------------------
// image geometry
// ----------------------------------------------------------------------

// pixels per row
`define IG_IMG_W 256

// rows per image
`define IG_IMG_H 256

// word address into the image and gradient memories
`define IG_ADDR_W 16

// ----------------------------------------------------------------------
// gradient write flow control
// ----------------------------------------------------------------------

// credits held right after reset and the upper bound of the pool
`define IG_GRAD_CREDITS 4

`endif
